//--- Makefile
# Verilator build and run for the RV32I execute stage testbench
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f build.f \
	  --top-module tb_rv_execute -Mdir obj_dir

run: compile
	./obj_dir/Vtb_rv_execute > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
	  echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
	  echo "simulation ended without a pass line"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
+incdir+rtl
+incdir+test
rtl/rv_ex_pkg.sv
rtl/rv_alu.sv
rtl/rv_branch_unit.sv
rtl/rv_ex_mem_reg.sv
rtl/rv_execute.sv
test/tb_rv_execute.sv

//--- rtl/rv_alu.sv
/*
  combinational only; operands are expected stable for the whole cycle
  o_be is zero outside loads and stores, o_wdata is always rs2 shifted to its lane
  misaligned half/word accesses are not trapped, lanes past byte 3 drop off
  func7 here is instruction bit 30 only
*/
`default_nettype none
`include "rv_ex_macros.svh"

module rv_alu
(
  input  wire rv_ex_pkg::alu_class_t  i_class,
  input  wire [2:0]                   i_func3,
  input  wire                         i_func7,    // instr bit 30
  input  wire [`RV_XLEN-1:0]          i_rs1_val,
  input  wire [`RV_XLEN-1:0]          i_rs2_val,
  input  wire [`RV_XLEN-1:0]          i_imm,      // sign-extended by decode
  input  wire [`RV_XLEN-1:0]          i_pc,
  output logic [`RV_XLEN-1:0]         o_result,
  output logic [`RV_BE_W-1:0]         o_be,
  output logic [`RV_XLEN-1:0]         o_wdata
);

  import rv_ex_pkg::*;

  logic [`RV_XLEN-1:0]    op_b;      // rs2 or imm
  logic [`RV_SHAMT_W-1:0] shamt;
  logic                   do_sub;    // only r-type has a real sub
  logic [`RV_XLEN-1:0]    sum;       // also the load/store address
  logic [`RV_XLEN-1:0]    diff;
  logic [`RV_XLEN-1:0]    sra_val;
  logic                   lt_s;
  logic                   lt_u;
  logic [`RV_XLEN-1:0]    alu_val;   // func3 selected result
  logic [1:0]             lane;      // byte offset in word
  logic [`RV_BE_W-1:0]    be_base;   // enables before lane shift
  logic                   is_mem;

  assign op_b   = (i_class == CLS_REG) ? i_rs2_val : i_imm;
  assign shamt  = op_b[`RV_SHAMT_W-1:0];  // upper amount bits ignored
  assign do_sub = (i_class == CLS_REG) && i_func7; // addi has imm bits at 30

  assign sum  = i_rs1_val + op_b;
  assign diff = i_rs1_val - op_b;

  // sign-filling right shift for sra and srai
  assign sra_val = $signed(i_rs1_val) >>> shamt;

  assign lt_s = $signed(i_rs1_val) < $signed(op_b);
  assign lt_u = i_rs1_val < op_b;

  always_comb
  begin
    case (i_func3)
      3'b000:  alu_val = do_sub ? diff : sum;                   // add sub addi
      3'b001:  alu_val = i_rs1_val << shamt;                    // sll slli
      3'b010:  alu_val = {{(`RV_XLEN-1){1'b0}}, lt_s};          // slt slti
      3'b011:  alu_val = {{(`RV_XLEN-1){1'b0}}, lt_u};          // sltu sltiu
      3'b100:  alu_val = i_rs1_val ^ op_b;                      // xor
      3'b101:  alu_val = i_func7 ? sra_val : (i_rs1_val >> shamt); // sra / srl
      3'b110:  alu_val = i_rs1_val | op_b;                      // or
      default: alu_val = i_rs1_val & op_b;                      // and
    endcase
  end

  // load/store lanes
  assign lane   = sum[1:0];
  assign is_mem = (i_class == CLS_LOAD) || (i_class == CLS_STORE);

  always_comb
  begin
    case (i_func3[1:0])  // bit 2 is the unsigned flag, same width
      2'b00:   be_base = 4'b0001;  // byte
      2'b01:   be_base = 4'b0011;  // half
      default: be_base = 4'b1111;  // word
    endcase
  end

  assign o_be    = is_mem ? (be_base << lane) : '0;
  assign o_wdata = i_rs2_val << {lane, 3'b000};  // 8 * offset

  always_comb
  begin
    case (i_class)
      CLS_LOAD,
      CLS_STORE:  o_result = sum;                    // effective address
      CLS_REG,
      CLS_IMM:    o_result = alu_val;
      CLS_LUI:    o_result = i_imm;
      CLS_AUIPC:  o_result = i_pc + i_imm;
      CLS_JAL,
      CLS_JALR:   o_result = i_pc + `RV_XLEN'd4;     // link value
      default:    o_result = '0;                     // branches write nothing
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rv_branch_unit.sv
/*
  combinational redirect for fetch, valid in the same cycle as the inputs
  o_redirect follows i_valid directly; o_redirect_pc is only meaningful when it is high
  unused branch func3 codes (010, 011) are treated as not taken
*/
`default_nettype none
`include "rv_ex_macros.svh"

module rv_branch_unit
(
  input  wire                         i_valid,
  input  wire rv_ex_pkg::alu_class_t  i_class,
  input  wire [2:0]                   i_func3,
  input  wire [`RV_XLEN-1:0]          i_rs1_val,
  input  wire [`RV_XLEN-1:0]          i_rs2_val,
  input  wire [`RV_XLEN-1:0]          i_imm,
  input  wire [`RV_XLEN-1:0]          i_pc,
  output logic                        o_redirect,
  output logic [`RV_XLEN-1:0]         o_redirect_pc
);

  import rv_ex_pkg::*;

  branch_cond_t        cond;
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                taken;      // condition result, branches only
  logic [`RV_XLEN-1:0] reg_tgt;    // rs1 + imm for jalr
  logic [`RV_XLEN-1:0] pc_tgt;     // pc + imm for jal and branches

  assign cond = branch_cond_t'(i_func3);

  assign eq   = (i_rs1_val == i_rs2_val);
  assign lt_s = $signed(i_rs1_val) < $signed(i_rs2_val);
  assign lt_u = i_rs1_val < i_rs2_val;

  always_comb
  begin
    case (cond)
      BR_EQ:   taken = eq;
      BR_NE:   taken = !eq;
      BR_LT:   taken = lt_s;
      BR_GE:   taken = !lt_s;
      BR_LTU:  taken = lt_u;
      BR_GEU:  taken = !lt_u;
      default: taken = 1'b0;  // reserved codes
    endcase
  end

  assign reg_tgt = i_rs1_val + i_imm;
  assign pc_tgt  = i_pc + i_imm;

  // jumps always redirect, branches only when taken
  always_comb
  begin
    o_redirect = 1'b0;
    if (i_valid)
    begin
      case (i_class)
        CLS_JAL,
        CLS_JALR:   o_redirect = 1'b1;
        CLS_BRANCH: o_redirect = taken;
        default:    o_redirect = 1'b0;
      endcase
    end
  end

  assign o_redirect_pc = (i_class == CLS_JALR) ? {reg_tgt[`RV_XLEN-1:1], 1'b0}
                                               : pc_tgt;

endmodule

`default_nettype wire

//--- rtl/rv_ex_macros.svh
/*
  fixed RV32I widths shared by the execute stage RTL and the testbench
  these are not per-instance parameters, changing them breaks the lane math
  RV_BE_W must stay RV_XLEN/8
*/
`ifndef RV_EX_MACROS_SVH
`define RV_EX_MACROS_SVH

// data and address width
`define RV_XLEN    32

// low operand bits taken as shift amount
`define RV_SHAMT_W 5

// byte lanes per word
`define RV_BE_W    4

`endif

//--- rtl/rv_ex_mem_reg.sv
/*
  EX/MEM register, one cycle latency, overwritten on every rising edge
  no stall input: whatever sits at the inputs is taken each clock
  control bits clear on reset and on cycles with i_valid low
  payload (result, data, lanes, size, rd) is not reset and is only valid with its control
*/
`default_nettype none
`include "rv_ex_macros.svh"

module rv_ex_mem_reg
(
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire                         i_valid,
  input  wire rv_ex_pkg::alu_class_t  i_class,
  input  wire [2:0]                   i_func3,
  input  wire [4:0]                   i_rd,
  input  wire [`RV_XLEN-1:0]          i_result,
  input  wire [`RV_BE_W-1:0]          i_be,
  input  wire [`RV_XLEN-1:0]          i_wdata,
  output logic                        o_mem_valid,  // an instruction occupies MEM
  output logic                        o_mem_read,
  output logic                        o_mem_write,
  output logic [2:0]                  o_mem_size,   // func3 passed on unchanged
  output logic [`RV_BE_W-1:0]         o_mem_be,
  output logic [`RV_XLEN-1:0]         o_result,
  output logic [`RV_XLEN-1:0]         o_mem_wdata,
  output logic                        o_reg_write,
  output logic [4:0]                  o_rd
);

  import rv_ex_pkg::*;

  logic is_load;
  logic is_store;
  logic writes_rd;   // class that produces a register value

  assign is_load   = (i_class == CLS_LOAD);
  assign is_store  = (i_class == CLS_STORE);
  assign writes_rd = !(is_store || (i_class == CLS_BRANCH));

  // control
  always_ff @(posedge i_clk)
  begin
    if (i_reset || !i_valid)
    begin
      o_mem_valid <= 1'b0;
      o_mem_read  <= 1'b0;
      o_mem_write <= 1'b0;
      o_reg_write <= 1'b0;
    end
    else
    begin
      o_mem_valid <= 1'b1;
      o_mem_read  <= is_load;
      o_mem_write <= is_store;
      o_reg_write <= writes_rd && (i_rd != 5'd0);  // x0 never written
    end
  end

  // payload
  always_ff @(posedge i_clk)
  begin
    o_mem_size  <= i_func3;
    o_mem_be    <= i_be;
    o_result    <= i_result;   // address for loads/stores
    o_mem_wdata <= i_wdata;
    o_rd        <= i_rd;
  end

endmodule

`default_nettype wire

//--- rtl/rv_ex_pkg.sv
/*
  types shared by the execute stage
  the class comes from decode already resolved, nothing here re-decodes opcodes
  branch_cond_t values equal the RV32I branch func3 field, 3'b010/3'b011 unused
*/
`default_nettype none

package rv_ex_pkg;

  // instruction class as handed over by decode
  typedef enum logic [3:0]
  {
    CLS_LOAD   = 4'd0,  // lb lh lw lbu lhu
    CLS_STORE  = 4'd1,  // sb sh sw
    CLS_BRANCH = 4'd2,  // beq bne blt bge bltu bgeu
    CLS_REG    = 4'd3,  // r-type, operand b is rs2
    CLS_IMM    = 4'd4,  // i-type alu, operand b is imm
    CLS_LUI    = 4'd5,
    CLS_AUIPC  = 4'd6,
    CLS_JAL    = 4'd7,
    CLS_JALR   = 4'd8
  } alu_class_t;

  // branch func3 codes
  typedef enum logic [2:0]
  {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,  // signed
    BR_GE  = 3'b101,  // signed
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_t;

endpackage

`default_nettype wire

//--- rtl/rv_execute.sv
/*
  RV32I execute stage top, one instruction per cycle, no stall or flush input
  redirect outputs are combinational from the inputs, memory side is registered
  operands must already be forwarded; this stage does no hazard checking
*/
`default_nettype none
`include "rv_ex_macros.svh"

module rv_execute
(
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire                         i_valid,
  input  wire rv_ex_pkg::alu_class_t  i_class,
  input  wire [2:0]                   i_func3,
  input  wire                         i_func7,
  input  wire [`RV_XLEN-1:0]          i_rs1_val,
  input  wire [`RV_XLEN-1:0]          i_rs2_val,
  input  wire [`RV_XLEN-1:0]          i_imm,
  input  wire [`RV_XLEN-1:0]          i_pc,
  input  wire [4:0]                   i_rd,
  output logic                        o_mem_valid,
  output logic                        o_mem_read,
  output logic                        o_mem_write,
  output logic [2:0]                  o_mem_size,
  output logic [`RV_BE_W-1:0]         o_mem_be,
  output logic [`RV_XLEN-1:0]         o_result,
  output logic [`RV_XLEN-1:0]         o_mem_wdata,
  output logic                        o_reg_write,
  output logic [4:0]                  o_rd,
  output logic                        o_redirect,
  output logic [`RV_XLEN-1:0]         o_redirect_pc
);

  logic [`RV_XLEN-1:0] alu_result;  // result or effective address
  logic [`RV_BE_W-1:0] alu_be;
  logic [`RV_XLEN-1:0] alu_wdata;

  rv_alu u_alu
  (
    .i_class   (i_class),
    .i_func3   (i_func3),
    .i_func7   (i_func7),
    .i_rs1_val (i_rs1_val),
    .i_rs2_val (i_rs2_val),
    .i_imm     (i_imm),
    .i_pc      (i_pc),
    .o_result  (alu_result),
    .o_be      (alu_be),
    .o_wdata   (alu_wdata)
  );

  // same-cycle fetch redirect
  rv_branch_unit u_branch
  (
    .i_valid       (i_valid),
    .i_class       (i_class),
    .i_func3       (i_func3),
    .i_rs1_val     (i_rs1_val),
    .i_rs2_val     (i_rs2_val),
    .i_imm         (i_imm),
    .i_pc          (i_pc),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  rv_ex_mem_reg u_ex_mem
  (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_class     (i_class),
    .i_func3     (i_func3),
    .i_rd        (i_rd),
    .i_result    (alu_result),
    .i_be        (alu_be),
    .i_wdata     (alu_wdata),
    .o_mem_valid (o_mem_valid),
    .o_mem_read  (o_mem_read),
    .o_mem_write (o_mem_write),
    .o_mem_size  (o_mem_size),
    .o_mem_be    (o_mem_be),
    .o_result    (o_result),
    .o_mem_wdata (o_mem_wdata),
    .o_reg_write (o_reg_write),
    .o_rd        (o_rd)
  );

endmodule

`default_nettype wire

//--- test/rv_ex_model.svh
/*
  reference model of the execute stage, written from the RV32I rules
  include inside the testbench module after importing rv_ex_pkg
  pure functions; the caller delays the registered outputs by one cycle
*/
`ifndef RV_EX_MODEL_SVH
`define RV_EX_MODEL_SVH

// signed compare done by flipping the sign bits
function automatic logic signed_less(logic [`RV_XLEN-1:0] a, logic [`RV_XLEN-1:0] b);
  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
endfunction

function automatic logic [`RV_XLEN-1:0] model_result(alu_class_t cls, logic [2:0] f3,
                                                    logic f7,
                                                    logic [`RV_XLEN-1:0] rs1,
                                                    logic [`RV_XLEN-1:0] rs2,
                                                    logic [`RV_XLEN-1:0] imm,
                                                    logic [`RV_XLEN-1:0] pc);
  logic [`RV_XLEN-1:0]   b;
  logic [4:0]            sh;
  logic [2*`RV_XLEN-1:0] ext;   // rs1 with 32 copies of its sign on top
  b   = (cls == CLS_REG) ? rs2 : imm;
  sh  = b[4:0];
  ext = {{`RV_XLEN{rs1[`RV_XLEN-1]}}, rs1} >> sh;
  case (cls)
    CLS_LOAD, CLS_STORE: return rs1 + imm;   // address
    CLS_LUI:             return imm;
    CLS_AUIPC:           return pc + imm;
    CLS_JAL, CLS_JALR:   return pc + 32'd4;  // link
    CLS_REG, CLS_IMM:
    begin
      case (f3)
        3'd0:    return (cls == CLS_REG && f7) ? rs1 - b : rs1 + b;
        3'd1:    return rs1 << sh;
        3'd2:    return {31'd0, signed_less(rs1, b)};
        3'd3:    return {31'd0, rs1 < b};
        3'd4:    return rs1 ^ b;
        3'd5:    return f7 ? ext[`RV_XLEN-1:0] : rs1 >> sh;
        3'd6:    return rs1 | b;
        default: return rs1 & b;
      endcase
    end
    default: return '0;  // branch result not used
  endcase
endfunction

function automatic logic [`RV_BE_W-1:0] model_be(logic [2:0] f3, logic [`RV_XLEN-1:0] addr);
  logic [`RV_BE_W-1:0] be;
  case (f3[1:0])
    2'b00:   be = 4'b0001;
    2'b01:   be = 4'b0011;
    default: be = 4'b1111;
  endcase
  case (addr[1:0])
    2'd1:    be = {be[2:0], 1'b0};
    2'd2:    be = {be[1:0], 2'b00};
    2'd3:    be = {be[0], 3'b000};
    default: be = be;
  endcase
  return be;
endfunction

// rs2 moved up to the lane of the address
function automatic logic [`RV_XLEN-1:0] model_wdata(logic [`RV_XLEN-1:0] rs2,
                                                   logic [`RV_XLEN-1:0] addr);
  case (addr[1:0])
    2'd0:    return rs2;
    2'd1:    return {rs2[23:0], 8'h00};
    2'd2:    return {rs2[15:0], 16'h0000};
    default: return {rs2[7:0], 24'h000000};
  endcase
endfunction

function automatic logic model_redirect(logic valid, alu_class_t cls, logic [2:0] f3,
                                        logic [`RV_XLEN-1:0] rs1, logic [`RV_XLEN-1:0] rs2);
  if (!valid)
    return 1'b0;
  if (cls == CLS_JAL || cls == CLS_JALR)
    return 1'b1;
  if (cls != CLS_BRANCH)
    return 1'b0;
  case (f3)
    3'b000:  return rs1 == rs2;
    3'b001:  return rs1 != rs2;
    3'b100:  return signed_less(rs1, rs2);
    3'b101:  return !signed_less(rs1, rs2);
    3'b110:  return rs1 < rs2;
    3'b111:  return !(rs1 < rs2);
    default: return 1'b0;
  endcase
endfunction

function automatic logic [`RV_XLEN-1:0] model_target(alu_class_t cls,
                                                    logic [`RV_XLEN-1:0] rs1,
                                                    logic [`RV_XLEN-1:0] imm,
                                                    logic [`RV_XLEN-1:0] pc);
  logic [`RV_XLEN-1:0] t;
  t = (cls == CLS_JALR) ? rs1 + imm : pc + imm;
  if (cls == CLS_JALR)
    t[0] = 1'b0;  // jalr drops bit 0
  return t;
endfunction

function automatic logic model_reg_write(alu_class_t cls, logic [4:0] rd);
  return (cls != CLS_STORE) && (cls != CLS_BRANCH) && (rd != 5'd0);
endfunction

`endif

//--- test/tb_rv_execute.sv
/*
  random self-checking testbench for the RV32I execute stage
  fixed seed, stops at the first mismatch
  redirect checked mid-cycle, EX/MEM outputs one cycle after the instruction
*/
`default_nettype none
`include "rv_ex_macros.svh"

module tb_rv_execute;

  timeunit 1ns;
  timeprecision 1ps;

  import rv_ex_pkg::*;

  `include "rv_ex_model.svh"

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_INSTR    = 2000;

  logic                i_clk;
  logic                i_reset;
  logic                i_valid;
  alu_class_t          i_class;
  logic [2:0]          i_func3;
  logic                i_func7;
  logic [`RV_XLEN-1:0] i_rs1_val;
  logic [`RV_XLEN-1:0] i_rs2_val;
  logic [`RV_XLEN-1:0] i_imm;
  logic [`RV_XLEN-1:0] i_pc;
  logic [4:0]          i_rd;
  logic                o_mem_valid;
  logic                o_mem_read;
  logic                o_mem_write;
  logic [2:0]          o_mem_size;
  logic [`RV_BE_W-1:0] o_mem_be;
  logic [`RV_XLEN-1:0] o_result;
  logic [`RV_XLEN-1:0] o_mem_wdata;
  logic                o_reg_write;
  logic [4:0]          o_rd;
  logic                o_redirect;
  logic [`RV_XLEN-1:0] o_redirect_pc;

  // instruction in the ALU now, and the one held in EX/MEM
  logic                cur_valid, prev_valid;
  alu_class_t          cur_cls, prev_cls;
  logic [2:0]          cur_f3, prev_f3;
  logic                cur_f7, prev_f7;
  logic [`RV_XLEN-1:0] cur_rs1, prev_rs1;
  logic [`RV_XLEN-1:0] cur_rs2, prev_rs2;
  logic [`RV_XLEN-1:0] cur_imm, prev_imm;
  logic [`RV_XLEN-1:0] cur_pc, prev_pc;
  logic [4:0]          cur_rd, prev_rd;

  rv_execute DUT
  (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_class       (i_class),
    .i_func3       (i_func3),
    .i_func7       (i_func7),
    .i_rs1_val     (i_rs1_val),
    .i_rs2_val     (i_rs2_val),
    .i_imm         (i_imm),
    .i_pc          (i_pc),
    .i_rd          (i_rd),
    .o_mem_valid   (o_mem_valid),
    .o_mem_read    (o_mem_read),
    .o_mem_write   (o_mem_write),
    .o_mem_size    (o_mem_size),
    .o_mem_be      (o_mem_be),
    .o_result      (o_result),
    .o_mem_wdata   (o_mem_wdata),
    .o_reg_write   (o_reg_write),
    .o_rd          (o_rd),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // corner values show up about half the time
  function automatic logic [`RV_XLEN-1:0] rand_operand();
    logic [31:0] pick;
    pick = $urandom_range(7, 0);
    case (pick)
      32'd0:   return 32'h0000_0000;
      32'd1:   return 32'hffff_ffff;
      32'd2:   return 32'h8000_0000;
      32'd3:   return 32'h7fff_ffff;
      default: return $urandom;
    endcase
  endfunction

  task automatic gen_instr();
    logic [31:0] r;
    r = $urandom_range(9, 0);
    cur_valid = (r != 32'd0);  // idle about one cycle in ten
    r = $urandom_range(8, 0);
    cur_cls = alu_class_t'(r[3:0]);
    r = $urandom;
    cur_f3 = r[2:0];
    case (cur_cls)
      CLS_BRANCH:
        if (cur_f3[2:1] == 2'b01)
          cur_f3[1] = 1'b0;           // 010/011 fold to eq/ne
      CLS_LOAD:
        if (cur_f3 == 3'd3 || cur_f3[2:1] == 2'b11)
          cur_f3[1] = 1'b0;           // keep lb lh lw lbu lhu
      CLS_STORE:
      begin
        cur_f3[2] = 1'b0;
        if (cur_f3 == 3'd3)
          cur_f3 = 3'd2;
      end
      default: cur_f3 = cur_f3;
    endcase
    cur_f7  = r[8];
    cur_rs1 = rand_operand();
    cur_rs2 = (r[12:10] == 3'd0) ? cur_rs1 : rand_operand();  // equal operands now and then
    cur_imm = rand_operand();
    cur_rd  = (r[23:21] == 3'd0) ? 5'd0 : r[20:16];
    r       = $urandom;
    cur_pc  = {r[31:2], 2'b00};
  endtask

  task automatic drive_instr(input logic reset);
    i_reset   <= reset;
    i_valid   <= cur_valid;
    i_class   <= cur_cls;
    i_func3   <= cur_f3;
    i_func7   <= cur_f7;
    i_rs1_val <= cur_rs1;
    i_rs2_val <= cur_rs2;
    i_imm     <= cur_imm;
    i_pc      <= cur_pc;
    i_rd      <= cur_rd;
  endtask

  task automatic check_same_cycle(input string tag);
    logic exp_redir;
    exp_redir = model_redirect(cur_valid, cur_cls, cur_f3, cur_rs1, cur_rs2);
    compare({tag, " redirect"}, 32'(exp_redir), 32'(o_redirect));
    if (exp_redir)
      compare({tag, " redirect_pc"}, model_target(cur_cls, cur_rs1, cur_imm, cur_pc),
              o_redirect_pc);
  endtask

  task automatic check_registered(input string tag);
    logic [`RV_XLEN-1:0] addr;
    addr = prev_rs1 + prev_imm;
    compare({tag, " mem_valid"}, 32'(prev_valid), 32'(o_mem_valid));
    if (!prev_valid)
    begin
      compare({tag, " mem_read"}, 32'd0, 32'(o_mem_read));
      compare({tag, " mem_write"}, 32'd0, 32'(o_mem_write));
      compare({tag, " reg_write"}, 32'd0, 32'(o_reg_write));
      return;
    end
    compare({tag, " mem_read"}, 32'(prev_cls == CLS_LOAD), 32'(o_mem_read));
    compare({tag, " mem_write"}, 32'(prev_cls == CLS_STORE), 32'(o_mem_write));
    compare({tag, " reg_write"}, 32'(model_reg_write(prev_cls, prev_rd)), 32'(o_reg_write));
    compare({tag, " rd"}, 32'(prev_rd), 32'(o_rd));
    if (prev_cls != CLS_BRANCH)
      compare({tag, " result"}, model_result(prev_cls, prev_f3, prev_f7, prev_rs1,
              prev_rs2, prev_imm, prev_pc), o_result);
    if (prev_cls == CLS_LOAD || prev_cls == CLS_STORE)
    begin
      compare({tag, " mem_be"}, 32'(model_be(prev_f3, addr)), 32'(o_mem_be));
      compare({tag, " mem_size"}, 32'(prev_f3), 32'(o_mem_size));
    end
    if (prev_cls == CLS_STORE)
      compare({tag, " mem_wdata"}, model_wdata(prev_rs2, addr), o_mem_wdata);
  endtask

  initial
  begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // limit set by the number of cycles the run needs, plus slack
  initial
  begin
    #((RESET_CYCLES + NUM_INSTR + 20) * CLK_PERIOD);
    $display("timeout: the run did not finish %0d instructions in time", NUM_INSTR);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    void'($urandom(77855));
    i_reset    = 1'b1;
    i_valid    = 1'b0;
    i_class    = CLS_LOAD;
    i_func3    = 3'd0;
    i_func7    = 1'b0;
    i_rs1_val  = '0;
    i_rs2_val  = '0;
    i_imm      = '0;
    i_pc       = '0;
    i_rd       = 5'd0;
    cur_valid  = 1'b0;
    cur_cls    = CLS_LOAD;
    cur_f3     = 3'd0;
    cur_f7     = 1'b0;
    cur_rs1    = '0;
    cur_rs2    = '0;
    cur_imm    = '0;
    cur_pc     = '0;
    cur_rd     = 5'd0;
    prev_valid = 1'b0;
    // valid instructions while in reset, EX/MEM must stay empty
    for (int c = 0; c < RESET_CYCLES; c++)
    begin
      @(posedge i_clk);
      gen_instr();
      cur_valid = 1'b1;
      drive_instr(c != RESET_CYCLES - 1);  // release after the last reset edge
      @(negedge i_clk);
      check_registered("reset");
      check_same_cycle("reset");
    end
    // one extra idle cycle at the end drains EX/MEM
    for (int n = 0; n <= NUM_INSTR; n++)
    begin
      @(posedge i_clk);
      prev_valid = cur_valid;
      prev_cls   = cur_cls;
      prev_f3    = cur_f3;
      prev_f7    = cur_f7;
      prev_rs1   = cur_rs1;
      prev_rs2   = cur_rs2;
      prev_imm   = cur_imm;
      prev_pc    = cur_pc;
      prev_rd    = cur_rd;
      if (n < NUM_INSTR)
        gen_instr();
      else
        cur_valid = 1'b0;
      drive_instr(1'b0);
      @(negedge i_clk);
      check_registered($sformatf("instr %0d", n - 1));
      check_same_cycle($sformatf("instr %0d", n));
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
